// File: compile.f
+incdir+.
fp16_mac_pkg.sv
fp16_unpack.sv
fp16_product.sv
fp16_align_add.sv
fp16_normalize_round.sv
fp16_mac.sv
tb_clk_gen.sv
tb_fp16_mac.sv

// File: Makefile
# Verilator build for the fp16 multiply-add; every variable can be overridden
VERILATOR ?= verilator
TOP       ?= tb_fp16_mac
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)

check: run
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "check failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fp16_mac_stim.txt
// columns: k x b tag expected_result, all hex
// first word is the vector count (hex)
0015
3C00 3C00 0000 0 3C00   // 1*1+0 exact
4000 4200 3C00 1 4700   // 2*3+1 with gap of 2
5800 5800 0400 2 7400   // gap over 21 drops b
3C00 3C00 1000 3 3C01   // half ulp rounds up
3C00 3C00 0C00 0 3C00   // quarter ulp truncated
4200 3C00 BC00 1 4000   // 3-1
3C00 3C00 C400 2 C200   // b dominates, 1-4
3E00 3C00 BC00 3 3800   // equal exp, difference goes negative
3C00 3C00 BC00 0 0000   // exact cancellation
0200 4000 0000 1 0400   // denormal k gives normal
0400 3800 0000 2 0200   // denormal result
0003 3800 0000 3 0002   // denormal 1.5 rounds to 2
0400 1000 03FF 0 0400   // denormal rounds into 0400
0001 3C00 0001 1 0002   // denormal plus denormal
3C01 3E00 0000 2 3E02   // product rounds half up
3E00 3E00 0000 3 4080   // product renormalize, 2.25
2E66 4900 8000 0 3C00   // round carry, negative zero addend
C100 4400 4200 1 C700   // -10+3
5C00 5C00 0000 2 7BFF   // overflow saturates
DC00 5C00 0000 3 FBFF   // negative overflow
7BFF 3C00 4C00 0 7BFF   // rounding carry overflows

// File: tb_fp16_mac.sv
`timescale 1ns/1ps
`include "fp16_mac_consts.svh"

module tb_fp16_mac;
    import fp16_mac_pkg::*;

    localparam int LATENCY    = 10;    // accepting edge to result edge
    localparam int RST_CYC    = 3;
    localparam int MAX_VEC    = 64;
    localparam int STIM_WORDS = 1 + 5 * MAX_VEC;

    logic               clk, rst, in_valid, out_valid;
    logic [`TAG_W-1:0]  tag_in, tag_out;
    fp16_word_u         k, x, b, result;

    logic [`FP16_W-1:0] stim_mem [0:STIM_WORDS-1];
    logic [`FP16_W-1:0] res_q[$];
    logic [`TAG_W-1:0]  tag_q[$];
    int                 due_q[$];
    int                 idx_q[$];

    int                 cyc = 0;
    int                 num_vec, cyc_limit, checked, value_errs, timing_errs;
    logic [`FP16_W-1:0] last_res;
    logic [`TAG_W-1:0]  last_tag;
    integer             seed;

    tb_clk_gen #(.PERIOD_NS(8)) tb_clk_gen_inst (.clk_o(clk));

    fp16_mac fp16_mac_inst (
        .clk(clk), .rst(rst), .in_valid_i(in_valid), .tag_i(tag_in),
        .k_i(k), .x_i(x), .b_i(b),
        .out_valid_o(out_valid), .tag_o(tag_out), .result_o(result)
    );

    task automatic report_counts();
        $display("errors: value %0d, timing %0d; results checked %0d of %0d",
                 value_errs, timing_errs, checked, num_vec);
    endtask

    task automatic drive_vector(input int n);
        int base;
        base = 1 + 5 * n;
        @(negedge clk);
        in_valid = 1'b1;
        k.raw    = stim_mem[base];
        x.raw    = stim_mem[base + 1];
        b.raw    = stim_mem[base + 2];
        tag_in   = stim_mem[base + 3][`TAG_W-1:0];
        res_q.push_back(stim_mem[base + 4]);
        tag_q.push_back(stim_mem[base + 3][`TAG_W-1:0]);
        due_q.push_back(cyc + LATENCY);    // taken at the coming rising edge
        idx_q.push_back(n);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic check_outputs();
        logic [`FP16_W-1:0] want_res;
        logic [`TAG_W-1:0]  want_tag;
        int                 want_due;
        int                 want_idx;
        if (out_valid) begin
            if (res_q.size() == 0) begin
                $display("out_valid_o high at cycle %0d with no result pending", cyc);
                timing_errs++;
            end else begin
                want_res = res_q.pop_front();
                want_tag = tag_q.pop_front();
                want_due = due_q.pop_front();
                want_idx = idx_q.pop_front();
                checked++;
                if (cyc != want_due) begin
                    $display("vector %0d came out at cycle %0d instead of cycle %0d",
                             want_idx, cyc, want_due);
                    timing_errs++;
                end
                if (result.raw !== want_res) begin
                    $display("ERR result_o got %h expected %h (vector %0d)",
                             result.raw, want_res, want_idx);
                    value_errs++;
                end
                if (tag_out !== want_tag) begin
                    $display("ERR tag_o got %h expected %h (vector %0d)",
                             tag_out, want_tag, want_idx);
                    value_errs++;
                end
            end
            last_res = result.raw;
            last_tag = tag_out;
        end else begin
            if (due_q.size() > 0 && cyc > due_q[0]) begin
                $display("vector %0d never came out, it was due at cycle %0d",
                         idx_q[0], due_q[0]);
                timing_errs++;
                want_res = res_q.pop_front();
                want_tag = tag_q.pop_front();
                want_due = due_q.pop_front();
                want_idx = idx_q.pop_front();
            end
            // outputs hold between strobes
            if (result.raw !== last_res) begin
                $display("ERR result_o got %h expected %h while idle", result.raw, last_res);
                value_errs++;
            end
            if (tag_out !== last_tag) begin
                $display("ERR tag_o got %h expected %h while idle", tag_out, last_tag);
                value_errs++;
            end
        end
    endtask

    ////////////////////////////////////////
    // cycle count and watchdog

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cyc, res_q.size());
            report_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (cyc >= RST_CYC)
            check_outputs();
    end

    ////////////////////////////////////////
    // stimulus

    initial begin
        int gap;
        rst         = 1'b1;
        in_valid    = 1'b0;
        tag_in      = '0;
        k           = '0;
        x           = '0;
        b           = '0;
        checked     = 0;
        value_errs  = 0;
        timing_errs = 0;
        last_res    = '0;    // reset value of result_o
        last_tag    = '0;
        seed        = 32'h94bee3f4;
        $readmemh("fp16_mac_stim.txt", stim_mem);
        num_vec   = 32'(stim_mem[0]);
        cyc_limit = num_vec * 4 + LATENCY + 50;
        if (num_vec < 1 || num_vec > MAX_VEC) begin
            $display("stimulus file holds a bad vector count of %0d", num_vec);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            repeat (RST_CYC) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < num_vec; i++) begin
                drive_vector(i);
                gap = $unsigned($random(seed)) % 4;
                if (i >= 4 && i < 10)
                    gap = 0;    // back-to-back burst
                idle_cycles(gap);
            end
            idle_cycles(1);
            while (res_q.size() > 0)
                @(negedge clk);
            idle_cycles(4);    // catch stray strobes
            @(posedge clk);
            report_counts();
            if (value_errs == 0 && timing_errs == 0 && checked == num_vec) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;   // first rising edge at half a period

endmodule

// File: fp16_mac.sv
`timescale 1ns/1ps
`include "fp16_mac_consts.svh"

module fp16_mac (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid_i,
    input  logic [`TAG_W-1:0]           tag_i,
    input  fp16_mac_pkg::fp16_word_u    k_i,
    input  fp16_mac_pkg::fp16_word_u    x_i,
    input  fp16_mac_pkg::fp16_word_u    b_i,
    output logic                        out_valid_o,
    output logic [`TAG_W-1:0]           tag_o,
    output fp16_mac_pkg::fp16_word_u    result_o
);
    // unpack to product
    logic                       up_valid, k_sign, x_sign, b_sign;
    logic [`TAG_W-1:0]          up_tag;
    logic signed [`IEXP_W-1:0]  k_exp, x_exp, b_exp;
    logic [`SIG_W-1:0]          k_sig, x_sig, b_sig;

    // product to align
    logic                       pr_valid, prod_sign, pr_b_sign;
    logic [`TAG_W-1:0]          pr_tag;
    logic signed [`IEXP_W-1:0]  prod_exp, pr_b_exp;
    logic [`PROD_W-1:0]         prod_sig;
    logic [`SIG_W-1:0]          pr_b_sig;

    // align to normalize
    logic                       al_valid, sum_sign;
    logic [`TAG_W-1:0]          al_tag;
    logic signed [`IEXP_W-1:0]  sum_exp;
    logic [`ACC_W-1:0]          sum_mag;

    fp16_unpack fp16_unpack_inst (
        .clk(clk), .rst(rst), .valid_i(in_valid_i), .tag_i(tag_i),
        .k_i(k_i), .x_i(x_i), .b_i(b_i),
        .valid_o(up_valid), .tag_o(up_tag),
        .k_sign_o(k_sign), .k_exp_o(k_exp), .k_sig_o(k_sig),
        .x_sign_o(x_sign), .x_exp_o(x_exp), .x_sig_o(x_sig),
        .b_sign_o(b_sign), .b_exp_o(b_exp), .b_sig_o(b_sig)
    );

    fp16_product fp16_product_inst (
        .clk(clk), .rst(rst), .valid_i(up_valid), .tag_i(up_tag),
        .k_sign_i(k_sign), .k_exp_i(k_exp), .k_sig_i(k_sig),
        .x_sign_i(x_sign), .x_exp_i(x_exp), .x_sig_i(x_sig),
        .b_sign_i(b_sign), .b_exp_i(b_exp), .b_sig_i(b_sig),
        .valid_o(pr_valid), .tag_o(pr_tag),
        .prod_sign_o(prod_sign), .prod_exp_o(prod_exp), .prod_sig_o(prod_sig),
        .b_sign_o(pr_b_sign), .b_exp_o(pr_b_exp), .b_sig_o(pr_b_sig)
    );

    fp16_align_add fp16_align_add_inst (
        .clk(clk), .rst(rst), .valid_i(pr_valid), .tag_i(pr_tag),
        .prod_sign_i(prod_sign), .prod_exp_i(prod_exp), .prod_sig_i(prod_sig),
        .b_sign_i(pr_b_sign), .b_exp_i(pr_b_exp), .b_sig_i(pr_b_sig),
        .valid_o(al_valid), .tag_o(al_tag),
        .sum_sign_o(sum_sign), .sum_exp_o(sum_exp), .sum_mag_o(sum_mag)
    );

    fp16_normalize_round fp16_normalize_round_inst (
        .clk(clk), .rst(rst), .valid_i(al_valid), .tag_i(al_tag),
        .sum_sign_i(sum_sign), .sum_exp_i(sum_exp), .sum_mag_i(sum_mag),
        .valid_o(out_valid_o), .tag_o(tag_o), .result_o(result_o)
    );

endmodule

// File: fp16_normalize_round.sv
`timescale 1ns/1ps
`include "fp16_mac_consts.svh"

module fp16_normalize_round (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  logic [`TAG_W-1:0]           tag_i,
    input  logic                        sum_sign_i,
    input  logic signed [`IEXP_W-1:0]   sum_exp_i,
    input  logic [`ACC_W-1:0]           sum_mag_i,
    output logic                        valid_o,
    output logic [`TAG_W-1:0]           tag_o,
    output fp16_mac_pkg::fp16_word_u    result_o
);
    import fp16_mac_pkg::*;

    localparam int LZ_W = $clog2(`ACC_W + 1);

    function automatic logic [LZ_W-1:0] lead_zeros(logic [`ACC_W-1:0] v);
        logic [LZ_W-1:0] n;
        n = LZ_W'(`ACC_W);
        for (int i = 0; i < `ACC_W; i++)
            if (v[i])
                n = LZ_W'(`ACC_W - 1 - i);   // highest set bit wins
        return n;
    endfunction

    logic [LZ_W-1:0]            lz;
    logic [`ACC_W-1:0]          norm;

    logic                       s8_valid, s8_sign, s8_rnd;
    logic [`TAG_W-1:0]          s8_tag;
    logic signed [`IEXP_W-1:0]  s8_exp;
    logic [`SIG_W-1:0]          s8_sig;

    logic [`IEXP_W-1:0]         dn_shift;
    logic [`SIG_W:0]            dn_ext;     // first discarded bit at 0
    logic [`SIG_W-1:0]          dn_sig;
    logic [`SIG_W:0]            nr_sum;

    logic                       s9_valid, s9_sign;
    logic [`TAG_W-1:0]          s9_tag;
    logic signed [`IEXP_W-1:0]  s9_exp;
    logic [`SIG_W-1:0]          s9_sig;

    fp16_word_u                 res_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            s8_valid <= 1'b0;
            s9_valid <= 1'b0;
        end else begin
            s8_valid <= valid_i;
            s9_valid <= s8_valid;
        end
    end

    ////////////////////////////////////////
    // stage 8 leading one

    always_comb begin
        lz   = lead_zeros(sum_mag_i);
        norm = sum_mag_i << lz;     // leading one to the top bit
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            s8_tag  <= tag_i;
            s8_sign <= sum_sign_i;
            s8_sig  <= norm[`ACC_W-1 -: `SIG_W];
            s8_rnd  <= norm[`ACC_W-1-`SIG_W];
            if (sum_mag_i == '0)
                s8_exp <= '0;
            else
                s8_exp <= sum_exp_i + `IEXP_W'(1) - `IEXP_W'(lz);
        end
    end

    ////////////////////////////////////////
    // stage 9 round

    always_comb begin
        dn_shift = `IEXP_W'(1) - s8_exp;
        dn_ext   = {s8_sig, 1'b0} >> dn_shift;
        dn_sig   = dn_ext[`SIG_W:1] + `SIG_W'(dn_ext[0]);
        nr_sum   = {1'b0, s8_sig} + {`SIG_W'(0), s8_rnd};
    end

    always_ff @(posedge clk) begin
        if (s8_valid) begin
            s9_tag  <= s8_tag;
            s9_sign <= s8_sign;
            if (s8_exp <= 0) begin
                s9_sig <= dn_sig;
                s9_exp <= dn_sig[`SIG_W-1] ? `IEXP_W'(1) : '0;  // rounded up to 0400
            end else if (nr_sum[`SIG_W]) begin
                s9_sig <= nr_sum[`SIG_W:1];
                s9_exp <= s8_exp + `IEXP_W'(1);
            end else begin
                s9_sig <= nr_sum[`SIG_W-1:0];
                s9_exp <= s8_exp;
            end
        end
    end

    ////////////////////////////////////////
    // stage 10 saturate and pack

    always_comb begin
        res_w = '0;
        if (s9_exp > `EXP_MAX) begin
            res_w.raw = {s9_sign, `MAX_FINITE};
        end else if (s9_sig != '0) begin
            res_w.f.sign = s9_sign;
            res_w.f.exp  = s9_exp[`EXP_W-1:0];
            res_w.f.frac = s9_sig[`MAN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o  <= 1'b0;
            tag_o    <= '0;
            result_o <= '0;
        end else begin
            valid_o <= s9_valid;
            if (s9_valid) begin
                tag_o    <= s9_tag;
                result_o <= res_w;
            end
        end
    end

    // no infinity or NaN ever leaves
    exp_range_a: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> result_o.f.exp != '1)
        else $error("result has all-ones exponent");

endmodule

// File: fp16_align_add.sv
`timescale 1ns/1ps
`include "fp16_mac_consts.svh"

module fp16_align_add (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  logic [`TAG_W-1:0]           tag_i,
    input  logic                        prod_sign_i,
    input  logic signed [`IEXP_W-1:0]   prod_exp_i,
    input  logic [`PROD_W-1:0]          prod_sig_i,
    input  logic                        b_sign_i,
    input  logic signed [`IEXP_W-1:0]   b_exp_i,
    input  logic [`SIG_W-1:0]           b_sig_i,
    output logic                        valid_o,
    output logic [`TAG_W-1:0]           tag_o,
    output logic                        sum_sign_o,
    output logic signed [`IEXP_W-1:0]   sum_exp_o,
    output logic [`ACC_W-1:0]           sum_mag_o
);
    logic                       prod_wins;
    logic [`IEXP_W-1:0]         exp_diff;   // negative wraps high
    logic [`ACC_W-1:0]          prod_mag, b_mag;

    logic                       s4_valid, s4_sign, s4_sub;
    logic [`TAG_W-1:0]          s4_tag;
    logic signed [`IEXP_W-1:0]  s4_exp;
    logic [`IEXP_W-1:0]         s4_shift;
    logic [`ACC_W-1:0]          s4_hi, s4_lo;

    logic                       s5_valid, s5_sign, s5_sub;
    logic [`TAG_W-1:0]          s5_tag;
    logic signed [`IEXP_W-1:0]  s5_exp;
    logic [`ACC_W-1:0]          s5_hi, s5_lo;

    logic                       s6_valid, s6_sign;
    logic [`TAG_W-1:0]          s6_tag;
    logic signed [`IEXP_W-1:0]  s6_exp;
    logic [`ACC_W:0]            s6_sum;     // top bit is the sign

    always_comb begin
        prod_wins = (b_exp_i == '0) || (prod_exp_i > b_exp_i);   // zero addend always loses
        exp_diff  = prod_wins ? prod_exp_i - b_exp_i : b_exp_i - prod_exp_i;
        // both leading ones land on bit 31
        prod_mag  = {1'b0, prod_sig_i[`PROD_W-2:0], {`SIG_W{1'b0}}};
        b_mag     = {1'b0, b_sig_i, {(`PROD_W-1){1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s4_valid <= 1'b0;
            s5_valid <= 1'b0;
            s6_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s4_valid <= valid_i;
            s5_valid <= s4_valid;
            s6_valid <= s5_valid;
            valid_o  <= s6_valid;
        end
    end

    ////////////////////////////////////////
    // stage 4 compare, stage 5 align

    always_ff @(posedge clk) begin
        if (valid_i) begin
            s4_tag   <= tag_i;
            s4_sub   <= prod_sign_i ^ b_sign_i;
            s4_sign  <= prod_wins ? prod_sign_i : b_sign_i;
            s4_exp   <= prod_wins ? prod_exp_i : b_exp_i;
            s4_hi    <= prod_wins ? prod_mag : b_mag;
            s4_lo    <= prod_wins ? b_mag : prod_mag;
            s4_shift <= (exp_diff > `IEXP_W'(31)) ? `IEXP_W'(31) : exp_diff;
        end
    end

    always_ff @(posedge clk) begin
        if (s4_valid) begin
            s5_tag  <= s4_tag;
            s5_sub  <= s4_sub;
            s5_sign <= s4_sign;
            s5_exp  <= s4_exp;
            s5_hi   <= s4_hi;
            s5_lo   <= (s4_shift > `IEXP_W'(`ALIGN_MAX)) ? '0 : s4_lo >> s4_shift;
        end
    end

    ////////////////////////////////////////
    // stage 6 add, stage 7 magnitude

    always_ff @(posedge clk) begin
        if (s5_valid) begin
            s6_tag  <= s5_tag;
            s6_sign <= s5_sign;
            s6_exp  <= s5_exp;
            s6_sum  <= s5_sub ? {1'b0, s5_hi} - {1'b0, s5_lo}
                              : {1'b0, s5_hi} + {1'b0, s5_lo};
        end
    end

    always_ff @(posedge clk) begin
        if (s6_valid) begin
            tag_o      <= s6_tag;
            sum_exp_o  <= s6_exp;
            sum_sign_o <= s6_sign ^ s6_sum[`ACC_W];
            sum_mag_o  <= s6_sum[`ACC_W] ? `ACC_W'(-s6_sum) : s6_sum[`ACC_W-1:0];
        end
    end

endmodule

// File: fp16_product.sv
`timescale 1ns/1ps
`include "fp16_mac_consts.svh"

module fp16_product (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  logic [`TAG_W-1:0]           tag_i,
    input  logic                        k_sign_i,
    input  logic signed [`IEXP_W-1:0]   k_exp_i,
    input  logic [`SIG_W-1:0]           k_sig_i,
    input  logic                        x_sign_i,
    input  logic signed [`IEXP_W-1:0]   x_exp_i,
    input  logic [`SIG_W-1:0]           x_sig_i,
    input  logic                        b_sign_i,
    input  logic signed [`IEXP_W-1:0]   b_exp_i,
    input  logic [`SIG_W-1:0]           b_sig_i,
    output logic                        valid_o,
    output logic [`TAG_W-1:0]           tag_o,
    output logic                        prod_sign_o,
    output logic signed [`IEXP_W-1:0]   prod_exp_o,
    output logic [`PROD_W-1:0]          prod_sig_o,
    output logic                        b_sign_o,
    output logic signed [`IEXP_W-1:0]   b_exp_o,
    output logic [`SIG_W-1:0]           b_sig_o
);
    logic                       s2_valid, s2_sign, s2_b_sign;
    logic [`TAG_W-1:0]          s2_tag;
    logic signed [`IEXP_W-1:0]  s2_exp, s2_b_exp;
    logic [`PROD_W-1:0]         s2_sig;
    logic [`SIG_W-1:0]          s2_b_sig;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s2_valid <= valid_i;
            valid_o  <= s2_valid;
        end
    end

    // stage 2 multiply
    always_ff @(posedge clk) begin
        if (valid_i) begin
            s2_tag    <= tag_i;
            s2_sign   <= k_sign_i ^ x_sign_i;
            s2_exp    <= k_exp_i + x_exp_i - `IEXP_W'(`EXP_BIAS);
            s2_sig    <= k_sig_i * x_sig_i;
            s2_b_sign <= b_sign_i;   // addend rides along
            s2_b_exp  <= b_exp_i;
            s2_b_sig  <= b_sig_i;
        end
    end

    // stage 3 product in [2,4) drops back to [1,2)
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            tag_o       <= s2_tag;
            prod_sign_o <= s2_sign;
            b_sign_o    <= s2_b_sign;
            b_exp_o     <= s2_b_exp;
            b_sig_o     <= s2_b_sig;
            if (s2_sig[`PROD_W-1]) begin
                prod_sig_o <= s2_sig >> 1;
                prod_exp_o <= s2_exp + `IEXP_W'(1);
            end else begin
                prod_sig_o <= s2_sig;
                prod_exp_o <= s2_exp;
            end
        end
    end

    // two normal operands leave the leading one at bit 20
    prod_norm_a: assert property (@(posedge clk) disable iff (rst)
        valid_o && $past(k_sig_i[`SIG_W-1] && x_sig_i[`SIG_W-1], 2)
            |-> !prod_sig_o[`PROD_W-1] && prod_sig_o[`PROD_W-2])
        else $error("product of normal operands not in [1,2) after renormalize");

endmodule

// File: fp16_unpack.sv
`timescale 1ns/1ps
`include "fp16_mac_consts.svh"

module fp16_unpack (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  logic [`TAG_W-1:0]           tag_i,
    input  fp16_mac_pkg::fp16_word_u    k_i,
    input  fp16_mac_pkg::fp16_word_u    x_i,
    input  fp16_mac_pkg::fp16_word_u    b_i,
    output logic                        valid_o,
    output logic [`TAG_W-1:0]           tag_o,
    output logic                        k_sign_o,
    output logic signed [`IEXP_W-1:0]   k_exp_o,
    output logic [`SIG_W-1:0]           k_sig_o,
    output logic                        x_sign_o,
    output logic signed [`IEXP_W-1:0]   x_exp_o,
    output logic [`SIG_W-1:0]           x_sig_o,
    output logic                        b_sign_o,
    output logic signed [`IEXP_W-1:0]   b_exp_o,
    output logic [`SIG_W-1:0]           b_sig_o
);
    import fp16_mac_pkg::*;

    // denormal gets exponent 1, true zero stays 0
    function automatic logic signed [`IEXP_W-1:0] int_exp(fp16_fields_s w);
        if (w.exp != '0)
            return `IEXP_W'(w.exp);
        return (w.frac != '0) ? `IEXP_W'(1) : '0;
    endfunction

    function automatic logic [`SIG_W-1:0] int_sig(fp16_fields_s w);
        return {w.exp != '0, w.frac};   // hidden bit only for normals
    endfunction

    always_ff @(posedge clk) begin
        if (rst)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i;
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            tag_o    <= tag_i;
            k_sign_o <= k_i.f.sign;
            k_exp_o  <= int_exp(k_i.f);
            k_sig_o  <= int_sig(k_i.f);
            x_sign_o <= x_i.f.sign;
            x_exp_o  <= int_exp(x_i.f);
            x_sig_o  <= int_sig(x_i.f);
            b_sign_o <= b_i.f.sign;
            b_exp_o  <= int_exp(b_i.f);
            b_sig_o  <= int_sig(b_i.f);
        end
    end

endmodule

// File: fp16_mac_pkg.sv
`include "fp16_mac_consts.svh"

package fp16_mac_pkg;

    typedef struct packed {
        logic                 sign;
        logic [`EXP_W-1:0]    exp;      // biased
        logic [`MAN_W-1:0]    frac;
    } fp16_fields_s;

    // raw bus word or its fields
    typedef union packed {
        logic [`FP16_W-1:0]   raw;
        fp16_fields_s         f;
    } fp16_word_u;

endpackage

// File: fp16_mac_consts.svh
`ifndef FP16_MAC_CONSTS_SVH
`define FP16_MAC_CONSTS_SVH

// half precision word layout
`define FP16_W      16
`define EXP_W       5
`define MAN_W       10
`define SIG_W       11      // fraction plus hidden bit
`define IEXP_W      7       // signed internal exponent
`define EXP_BIAS    15

// datapath widths
`define PROD_W      22
`define ACC_W       33      // add result carries one more bit for the sign

// result limits
`define ALIGN_MAX   21      // larger shifts leave nothing of the addend
`define EXP_MAX     30
`define MAX_FINITE  15'h7BFF

`define TAG_W       2

`endif
